// File: logic/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Memory geometry
`define WORD_SIZE 16 // Bits per word
`define MEMORY_SIZE 256 // Words in main memory
`define MEMORY_ADDR_BITS 8 // Address bits that select a memory word

// Every memory request waits this many cycles
`define MEM_STALL_COUNT 4

// Block and cache geometry
`define BLOCK_WORDS 4 // Words per block and per cache line
`define BLOCK_OFFSET_BITS 2 // Word within a block
`define CACHE_LINES 4 // Lines in each cache
`define CACHE_INDEX_BITS 2 // Line select
`define CACHE_TAG_LSB (`BLOCK_OFFSET_BITS + `CACHE_INDEX_BITS) // Lowest tag bit

`endif

// File: logic/mem_pkg.sv
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;
	typedef logic [`WORD_SIZE-1:0] mem_addr_t; // Only the low bits reach memory
	typedef logic [`BLOCK_WORDS*`WORD_SIZE-1:0] block_t; // Word zero in the low bits

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_STALL,
		PORT_DONE // One cycle that ignores the held request
	} port_state_t;

	typedef enum logic [1:0] {
		CACHE_IDLE,
		CACHE_FILL,
		CACHE_WRITE
	} cache_state_t;

	// Pick one word out of a block
	function automatic word_t block_word(block_t block, logic [`BLOCK_OFFSET_BITS-1:0] offset);
		return block[offset*`WORD_SIZE +: `WORD_SIZE];
	endfunction

endpackage

`default_nettype wire

// File: logic/block_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module block_memory import mem_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	// Port one, instruction reads
	input  logic      imem_read,
	input  mem_addr_t imem_address,
	output block_t    imem_block,
	output logic      imem_ready,
	// Port two, data reads and writes
	input  logic      dmem_read,
	input  logic      dmem_write,
	input  mem_addr_t dmem_address,
	input  word_t     dmem_write_word,
	output block_t    dmem_block,
	output logic      dmem_ready,
	output logic      dmem_ack
);

	localparam int COUNT_BITS = $clog2(`MEM_STALL_COUNT + 1);
	localparam logic [COUNT_BITS-1:0] LAST_STALL = COUNT_BITS'(`MEM_STALL_COUNT - 1);

	word_t memory [`MEMORY_SIZE];

	port_state_t state1;
	port_state_t state2;
	logic [COUNT_BITS-1:0] count1; // Cycles the request has been seen
	logic [COUNT_BITS-1:0] count2;
	logic done1;
	logic done2;

	// Four consecutive words, wrapping at the top of memory
	function automatic block_t read_block(mem_addr_t address);
		block_t block;
		logic [`MEMORY_ADDR_BITS-1:0] base;
		base = address[`MEMORY_ADDR_BITS-1:0];
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			block[i*`WORD_SIZE +: `WORD_SIZE] = memory[base + `MEMORY_ADDR_BITS'(i)];
		end
		return block;
	endfunction

	assign done1 = (state1 == PORT_STALL) && (count1 == LAST_STALL);
	assign done2 = (state2 == PORT_STALL) && (count2 == LAST_STALL);

	// Port one control
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state1 <= PORT_IDLE;
			count1 <= '0;
			imem_ready <= 1'b0;
		end else begin
			imem_ready <= 1'b0;
			case (state1)
				PORT_IDLE: if (imem_read) begin
					state1 <= PORT_STALL;
					count1 <= COUNT_BITS'(1);
				end
				PORT_STALL: if (done1) begin
					state1 <= PORT_DONE;
					count1 <= '0;
					imem_ready <= 1'b1;
				end else begin
					count1 <= count1 + 1'b1;
				end
				default: state1 <= PORT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (done1) begin
			imem_block <= read_block(imem_address);
		end
	end

	// Port two control
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state2 <= PORT_IDLE;
			count2 <= '0;
			dmem_ready <= 1'b0;
			dmem_ack <= 1'b0;
		end else begin
			dmem_ready <= 1'b0;
			dmem_ack <= 1'b0;
			case (state2)
				PORT_IDLE: if (dmem_read || dmem_write) begin
					state2 <= PORT_STALL;
					count2 <= COUNT_BITS'(1);
				end
				PORT_STALL: if (done2) begin
					state2 <= PORT_DONE;
					count2 <= '0;
					dmem_ack <= dmem_write; // Write finishes with ack
					dmem_ready <= !dmem_write;
				end else begin
					count2 <= count2 + 1'b1;
				end
				default: state2 <= PORT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (done2 && !dmem_write) begin
			dmem_block <= read_block(dmem_address);
		end
	end

	// Storage, cleared at reset and written only by port two
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `MEMORY_SIZE; i++) begin
				memory[i] <= '0;
			end
		end else if (done2 && dmem_write) begin
			memory[dmem_address[`MEMORY_ADDR_BITS-1:0]] <= dmem_write_word;
		end
	end

endmodule

`default_nettype wire

// File: logic/instruction_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module instruction_cache import mem_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  logic      fetch_req,
	input  mem_addr_t fetch_address,
	output word_t     fetch_word,
	output logic      fetch_ready,
	output logic      imem_read,
	output mem_addr_t imem_address,
	input  block_t    imem_block,
	input  logic      imem_ready
);

	cache_state_t state;

	logic valid [`CACHE_LINES];
	logic [`WORD_SIZE-1:`CACHE_TAG_LSB] tags [`CACHE_LINES];
	block_t lines [`CACHE_LINES];

	logic [`CACHE_INDEX_BITS-1:0] index;
	logic [`BLOCK_OFFSET_BITS-1:0] offset;
	logic hit;
	logic accept;
	logic fill_done;

	assign index = fetch_address[`CACHE_TAG_LSB-1:`BLOCK_OFFSET_BITS];
	assign offset = fetch_address[`BLOCK_OFFSET_BITS-1:0];
	assign hit = valid[index] && (tags[index] == fetch_address[`WORD_SIZE-1:`CACHE_TAG_LSB]);
	// Skip the cycle of our own ready pulse, the request is still held then
	assign accept = (state == CACHE_IDLE) && fetch_req && !fetch_ready;
	assign fill_done = (state == CACHE_FILL) && imem_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= CACHE_IDLE;
			fetch_ready <= 1'b0;
			imem_read <= 1'b0;
			for (int i = 0; i < `CACHE_LINES; i++) begin
				valid[i] <= 1'b0;
			end
		end else begin
			fetch_ready <= 1'b0;
			case (state)
				CACHE_IDLE: if (accept) begin
					if (hit) begin
						fetch_ready <= 1'b1;
					end else begin
						imem_read <= 1'b1; // Held until imem_ready
						state <= CACHE_FILL;
					end
				end
				CACHE_FILL: if (fill_done) begin
					imem_read <= 1'b0;
					valid[index] <= 1'b1;
					fetch_ready <= 1'b1; // Answer right after the refill
					state <= CACHE_IDLE;
				end
				default: state <= CACHE_IDLE;
			endcase
		end
	end

	// Tags, line data and the returned word
	always_ff @(posedge clk) begin
		if (accept && !hit) begin
			imem_address <= {fetch_address[`WORD_SIZE-1:`BLOCK_OFFSET_BITS],
				{`BLOCK_OFFSET_BITS{1'b0}}}; // Block aligned
		end
		if (fill_done) begin
			tags[index] <= fetch_address[`WORD_SIZE-1:`CACHE_TAG_LSB];
			lines[index] <= imem_block;
			fetch_word <= block_word(imem_block, offset);
		end else if (accept && hit) begin
			fetch_word <= block_word(lines[index], offset);
		end
	end

endmodule

`default_nettype wire

// File: logic/data_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module data_cache import mem_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  logic      load_req,
	input  logic      store_req,
	input  mem_addr_t data_address,
	input  word_t     store_word,
	output word_t     load_word,
	output logic      data_ready,
	output logic      dmem_read,
	output logic      dmem_write,
	output mem_addr_t dmem_address,
	output word_t     dmem_write_word,
	input  block_t    dmem_block,
	input  logic      dmem_ready,
	input  logic      dmem_ack
);

	cache_state_t state;

	logic valid [`CACHE_LINES];
	logic [`WORD_SIZE-1:`CACHE_TAG_LSB] tags [`CACHE_LINES];
	block_t lines [`CACHE_LINES];

	logic [`CACHE_INDEX_BITS-1:0] index;
	logic [`BLOCK_OFFSET_BITS-1:0] offset;
	logic hit;
	logic accept;
	logic load_accept;
	logic store_accept;
	logic fill_done;

	assign index = data_address[`CACHE_TAG_LSB-1:`BLOCK_OFFSET_BITS];
	assign offset = data_address[`BLOCK_OFFSET_BITS-1:0];
	assign hit = valid[index] && (tags[index] == data_address[`WORD_SIZE-1:`CACHE_TAG_LSB]);
	assign accept = (state == CACHE_IDLE) && !data_ready; // Held request after a pulse
	assign load_accept = accept && load_req;
	assign store_accept = accept && store_req && !load_req;
	assign fill_done = (state == CACHE_FILL) && dmem_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= CACHE_IDLE;
			data_ready <= 1'b0;
			dmem_read <= 1'b0;
			dmem_write <= 1'b0;
			for (int i = 0; i < `CACHE_LINES; i++) begin
				valid[i] <= 1'b0;
			end
		end else begin
			data_ready <= 1'b0;
			case (state)
				CACHE_IDLE: begin
					if (load_accept) begin
						if (hit) begin
							data_ready <= 1'b1;
						end else begin
							dmem_read <= 1'b1;
							state <= CACHE_FILL;
						end
					end else if (store_accept) begin
						dmem_write <= 1'b1; // Write through on every store
						state <= CACHE_WRITE;
					end
				end
				CACHE_FILL: if (fill_done) begin
					dmem_read <= 1'b0;
					valid[index] <= 1'b1;
					data_ready <= 1'b1;
					state <= CACHE_IDLE;
				end
				CACHE_WRITE: if (dmem_ack) begin
					dmem_write <= 1'b0;
					data_ready <= 1'b1;
					state <= CACHE_IDLE;
				end
				default: state <= CACHE_IDLE;
			endcase
		end
	end

	// Line contents, memory address and write data
	always_ff @(posedge clk) begin
		if (load_accept && !hit) begin
			dmem_address <= {data_address[`WORD_SIZE-1:`BLOCK_OFFSET_BITS],
				{`BLOCK_OFFSET_BITS{1'b0}}};
		end
		if (store_accept) begin
			dmem_address <= data_address; // Single word, no alignment
			dmem_write_word <= store_word;
			if (hit) begin
				lines[index][offset*`WORD_SIZE +: `WORD_SIZE] <= store_word; // Miss stays out
			end
		end
		if (fill_done) begin
			tags[index] <= data_address[`WORD_SIZE-1:`CACHE_TAG_LSB];
			lines[index] <= dmem_block;
			load_word <= block_word(dmem_block, offset);
		end else if (load_accept && hit) begin
			load_word <= block_word(lines[index], offset);
		end
	end

endmodule

`default_nettype wire

// File: logic/memory_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module memory_subsystem import mem_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	// Fetch side
	input  logic      fetch_req,
	input  mem_addr_t fetch_address,
	output word_t     fetch_word,
	output logic      fetch_ready,
	// Data side
	input  logic      load_req,
	input  logic      store_req,
	input  mem_addr_t data_address,
	input  word_t     store_word,
	output word_t     load_word,
	output logic      data_ready
);

	logic      imem_read;
	mem_addr_t imem_address;
	block_t    imem_block;
	logic      imem_ready;

	logic      dmem_read;
	logic      dmem_write;
	mem_addr_t dmem_address;
	word_t     dmem_write_word;
	block_t    dmem_block;
	logic      dmem_ready;
	logic      dmem_ack;

	instruction_cache u_icache (.*); // Memory port one
	data_cache u_dcache (.*); // Memory port two
	block_memory u_memory (.*);

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset_n
);

	localparam int HALF_PERIOD = 20; // 40 ns clock
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Release a little after the edge so the DUT sees a clean level
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/memory_subsystem_checker.sv
`timescale 1ns/100ps
`default_nettype none

module memory_subsystem_checker (
	input logic clk,
	input logic reset_n,
	input logic fetch_req,
	input logic fetch_ready,
	input logic load_req,
	input logic store_req,
	input logic data_ready
);

	localparam int QUIET_CYCLES = 8; // No answer this soon after reset

	int failure_count = 0; // Failed assertions so far

	fetch_pulse_single: assert property (@(posedge clk) disable iff (!reset_n)
		fetch_ready |=> !fetch_ready)
		else begin
			$error("fetch_ready high two cycles in a row");
			failure_count++;
		end

	data_pulse_single: assert property (@(posedge clk) disable iff (!reset_n)
		data_ready |=> !data_ready)
		else begin
			$error("data_ready high two cycles in a row");
			failure_count++;
		end

	one_data_request: assert property (@(posedge clk) disable iff (!reset_n)
		!(load_req && store_req))
		else begin
			$error("load_req and store_req high together");
			failure_count++;
		end

	// The cache decided one edge earlier while the request was held
	fetch_ready_requested: assert property (@(posedge clk) disable iff (!reset_n)
		fetch_ready |-> $past(fetch_req))
		else begin
			$error("fetch_ready without fetch_req");
			failure_count++;
		end

	data_ready_requested: assert property (@(posedge clk) disable iff (!reset_n)
		data_ready |-> $past(load_req || store_req))
		else begin
			$error("data_ready without request");
			failure_count++;
		end

	quiet_after_reset: assert property (@(posedge clk)
		$rose(reset_n) |-> (!fetch_ready && !data_ready) [*QUIET_CYCLES])
		else begin
			$error("Ready pulse too soon after reset release");
			failure_count++;
		end

endmodule

bind memory_subsystem memory_subsystem_checker u_checker (
	.clk(clk),
	.reset_n(reset_n),
	.fetch_req(fetch_req),
	.fetch_ready(fetch_ready),
	.load_req(load_req),
	.store_req(store_req),
	.data_ready(data_ready)
);

`default_nettype wire

// File: testbench/memory_subsystem_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module memory_subsystem_tb import mem_pkg::*; ();

	localparam int SEED = 45;
	localparam int DRIVE_DELAY = 2; // After the rising edge
	localparam int SAMPLE_DELAY = 1;
	localparam int SETTLE_CYCLES = 8;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_LOADS = 64;
	localparam int NUM_FETCHES = 64;
	localparam int NUM_MIXED = 64;
	localparam int NUM_DIRECTED = 8; // Five operations per round
	localparam int TOTAL_OPS = `MEMORY_SIZE + NUM_LOADS + NUM_FETCHES + NUM_MIXED
		+ NUM_DIRECTED * 5;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * (`MEM_STALL_COUNT + 8) + RESET_CYCLES + 100;
	localparam int HIT_CYCLES = 1;
	localparam int MISS_CYCLES = `MEM_STALL_COUNT + 2; // Memory stall, refill, answer
	localparam int STORE_CYCLES = `MEM_STALL_COUNT + 2;

	logic clk;
	logic reset_n;
	logic fetch_req;
	mem_addr_t fetch_address;
	word_t fetch_word;
	logic fetch_ready;
	logic load_req;
	logic store_req;
	mem_addr_t data_address;
	word_t store_word;
	word_t load_word;
	logic data_ready;

	// Reference model
	word_t model_mem [`MEMORY_SIZE];
	logic icache_valid [`CACHE_LINES];
	logic [`WORD_SIZE-1:`CACHE_TAG_LSB] icache_tag [`CACHE_LINES];
	logic dcache_valid [`CACHE_LINES];
	logic [`WORD_SIZE-1:`CACHE_TAG_LSB] dcache_tag [`CACHE_LINES];

	int cycle_count = 0;

	tb_clock_gen u_clock_gen (
		.clk(clk),
		.reset_n(reset_n)
	);

	memory_subsystem DUT (
		.clk(clk),
		.reset_n(reset_n),
		.fetch_req(fetch_req),
		.fetch_address(fetch_address),
		.fetch_word(fetch_word),
		.fetch_ready(fetch_ready),
		.load_req(load_req),
		.store_req(store_req),
		.data_address(data_address),
		.store_word(store_word),
		.load_word(load_word),
		.data_ready(data_ready)
	);

	task automatic report_failure(input string text);
		$display("%s", text);
		$display("Test failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_fetch(input word_t actual, input word_t expected, input mem_addr_t address);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch at %0t: fetch from %h returned %h, expected %h",
				$time, address, actual, expected));
		end
	endtask

	task automatic check_load(input word_t actual, input word_t expected, input mem_addr_t address);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch at %0t: load from %h returned %h, expected %h",
				$time, address, actual, expected));
		end
	endtask

	task automatic check_latency(input int actual, input int expected, input string operation,
		input mem_addr_t address);
		if (actual != expected) begin
			report_failure($sformatf("Mismatch at %0t: %s at %h took %0d cycles, expected %0d",
				$time, operation, address, actual, expected));
		end
	endtask

	task automatic fetch_instruction(input mem_addr_t address);
		logic [`CACHE_INDEX_BITS-1:0] index;
		logic hit;
		int cycles;
		word_t result;
		index = address[`CACHE_TAG_LSB-1:`BLOCK_OFFSET_BITS];
		hit = icache_valid[index] && (icache_tag[index] == address[`WORD_SIZE-1:`CACHE_TAG_LSB]);
		@(posedge clk);
		#DRIVE_DELAY;
		fetch_req = 1'b1;
		fetch_address = address;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			#SAMPLE_DELAY;
		end while (!fetch_ready);
		result = fetch_word;
		#(DRIVE_DELAY - SAMPLE_DELAY);
		fetch_req = 1'b0;
		check_fetch(result, model_mem[address[`MEMORY_ADDR_BITS-1:0]], address);
		check_latency(cycles, hit ? HIT_CYCLES : MISS_CYCLES, "fetch", address);
		icache_valid[index] = 1'b1;
		icache_tag[index] = address[`WORD_SIZE-1:`CACHE_TAG_LSB];
	endtask

	task automatic load_data(input mem_addr_t address);
		logic [`CACHE_INDEX_BITS-1:0] index;
		logic hit;
		int cycles;
		word_t result;
		index = address[`CACHE_TAG_LSB-1:`BLOCK_OFFSET_BITS];
		hit = dcache_valid[index] && (dcache_tag[index] == address[`WORD_SIZE-1:`CACHE_TAG_LSB]);
		@(posedge clk);
		#DRIVE_DELAY;
		load_req = 1'b1;
		data_address = address;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			#SAMPLE_DELAY;
		end while (!data_ready);
		result = load_word;
		#(DRIVE_DELAY - SAMPLE_DELAY);
		load_req = 1'b0;
		check_load(result, model_mem[address[`MEMORY_ADDR_BITS-1:0]], address);
		check_latency(cycles, hit ? HIT_CYCLES : MISS_CYCLES, "load", address);
		dcache_valid[index] = 1'b1;
		dcache_tag[index] = address[`WORD_SIZE-1:`CACHE_TAG_LSB];
	endtask

	// Write-through stores leave the mirror unchanged
	task automatic store_data(input mem_addr_t address, input word_t value);
		int cycles;
		@(posedge clk);
		#DRIVE_DELAY;
		store_req = 1'b1;
		data_address = address;
		store_word = value;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			#SAMPLE_DELAY;
		end while (!data_ready);
		#(DRIVE_DELAY - SAMPLE_DELAY);
		store_req = 1'b0;
		check_latency(cycles, STORE_CYCLES, "store", address);
		model_mem[address[`MEMORY_ADDR_BITS-1:0]] = value;
	endtask

	function automatic mem_addr_t upper_address();
		return mem_addr_t'(`MEMORY_SIZE / 2 + $urandom_range(`MEMORY_SIZE / 2 - 1));
	endfunction

	// Load a block and store into it so the next load must hit
	task automatic store_then_hit();
		mem_addr_t address;
		mem_addr_t neighbour;
		address = upper_address();
		neighbour = {address[`WORD_SIZE-1:`BLOCK_OFFSET_BITS],
			`BLOCK_OFFSET_BITS'($urandom_range(`BLOCK_WORDS - 1))};
		load_data(address);
		store_data(neighbour, word_t'($urandom()));
		load_data(neighbour);
	endtask

	task automatic store_without_allocate();
		mem_addr_t address;
		logic [`CACHE_INDEX_BITS-1:0] index;
		address = upper_address();
		index = address[`CACHE_TAG_LSB-1:`BLOCK_OFFSET_BITS];
		if (dcache_valid[index] && dcache_tag[index] == address[`WORD_SIZE-1:`CACHE_TAG_LSB]) begin
			address[`CACHE_TAG_LSB] = ~address[`CACHE_TAG_LSB]; // Same line but another tag
		end
		store_data(address, word_t'($urandom()));
		load_data(address);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (DUT.u_checker.failure_count != 0) begin
			report_failure("An assertion on the DUT ports failed");
		end else if (cycle_count == TIMEOUT_CYCLES) begin
			report_failure($sformatf("Timeout: the run did not finish in %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	initial begin
		fetch_req = 1'b0;
		fetch_address = '0;
		load_req = 1'b0;
		store_req = 1'b0;
		data_address = '0;
		store_word = '0;
		for (int i = 0; i < `MEMORY_SIZE; i++) begin
			model_mem[i] = '0;
		end
		for (int i = 0; i < `CACHE_LINES; i++) begin
			icache_valid[i] = 1'b0;
			dcache_valid[i] = 1'b0;
		end
		void'($urandom(SEED));
		wait (reset_n === 1'b1);
		repeat (SETTLE_CYCLES) @(posedge clk);

		for (int a = 0; a < `MEMORY_SIZE; a++) begin
			store_data(mem_addr_t'(a), word_t'($urandom()));
		end
		for (int i = 0; i < NUM_LOADS; i++) begin
			load_data(mem_addr_t'($urandom_range(`MEMORY_SIZE - 1)));
		end

		// Fetches stay below the data traffic because the caches are not coherent
		fork
			begin
				for (int i = 0; i < NUM_FETCHES; i++) begin
					fetch_instruction(mem_addr_t'($urandom_range(`MEMORY_SIZE / 2 - 1)));
				end
			end
			begin
				for (int i = 0; i < NUM_MIXED; i++) begin
					if ($urandom_range(1)) begin
						store_data(upper_address(), word_t'($urandom()));
					end else begin
						load_data(upper_address());
					end
				end
			end
		join

		for (int i = 0; i < NUM_DIRECTED; i++) begin
			store_then_hit();
			store_without_allocate();
		end

		if (DUT.u_checker.failure_count == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			report_failure("An assertion on the DUT ports failed");
		end
	end

endmodule

`default_nettype wire

// File: memory_subsystem.f
+incdir+logic
logic/mem_pkg.sv
logic/block_memory.sv
logic/instruction_cache.sv
logic/data_cache.sv
logic/memory_subsystem.sv
testbench/tb_clock_gen.sv
testbench/memory_subsystem_checker.sv
testbench/memory_subsystem_tb.sv

// File: Bender.yml
package:
  name: memory_subsystem

sources:
  - include_dirs:
      - logic
    files:
      - logic/mem_pkg.sv
      - logic/block_memory.sv
      - logic/instruction_cache.sv
      - logic/data_cache.sv
      - logic/memory_subsystem.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_clock_gen.sv
      - testbench/memory_subsystem_checker.sv
      - testbench/memory_subsystem_tb.sv
